/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // One hold bit per stage, fetch in bit 0
  localparam int STAGE_NUM = 5;

  // addi x0, x0, 0
  localparam inst_t NOP = 32'h0000_0013;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASSB
  } alu_op_e;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

endpackage

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic              clk,
  input  logic              rstn,
  input  logic              we_i,
  input  cpu_pkg::reg_idx_t waddr_i,
  input  cpu_pkg::word_t    wdata_i,
  input  cpu_pkg::reg_idx_t raddr1_i,
  input  cpu_pkg::reg_idx_t raddr2_i,
  output cpu_pkg::word_t    rdata1_o,
  output cpu_pkg::word_t    rdata2_o
);
  import cpu_pkg::*;

  word_t regs [32];
  logic  wr_en;

  // x0 is never written, so it stays at zero
  assign wr_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Write-through so decode sees the value written this cycle
  assign rdata1_o = (wr_en && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (wr_en && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

/* design/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch #(
  parameter cpu_pkg::addr_t RESET_PC = 32'h0
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic [cpu_pkg::STAGE_NUM-1:0] stall_i,
  input  logic                          flush_i,
  input  logic                          branch_taken_i,
  input  cpu_pkg::addr_t                branch_target_i,
  input  cpu_pkg::inst_t                inst_i,
  output logic                          inst_read_o,
  output cpu_pkg::addr_t                inst_addr_o,
  output cpu_pkg::addr_t                id_pc_o,
  output cpu_pkg::inst_t                id_inst_o
);
  import cpu_pkg::*;

  addr_t pc;
  logic  ce;

  // Fetch enable comes up one cycle after reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ce <= 1'b0;
    end else begin
      ce <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc <= RESET_PC;
    end else if (ce && !stall_i[0]) begin
      pc <= branch_taken_i ? branch_target_i : pc + 32'd4;
    end
  end

  assign inst_read_o = ce;
  assign inst_addr_o = pc;

  // IF/ID register
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_pc_o   <= '0;
      id_inst_o <= NOP;
    end else if (!stall_i[1]) begin
      id_pc_o <= pc;
      // Wrong-path instruction or nothing fetched yet
      if (flush_i || !ce || stall_i[0]) begin
        id_inst_o <= NOP;
      end else begin
        id_inst_o <= inst_i;
      end
    end
  end

endmodule

`default_nettype wire

/* design/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode (
  input  cpu_pkg::addr_t    pc_i,
  input  cpu_pkg::inst_t    inst_i,
  input  cpu_pkg::word_t    rs1_data_i,
  input  cpu_pkg::word_t    rs2_data_i,
  input  logic              ex_wreg_i,
  input  cpu_pkg::reg_idx_t ex_rd_i,
  input  cpu_pkg::word_t    ex_result_i,
  input  logic              ex_memrd_i,
  input  logic              mem_wreg_i,
  input  cpu_pkg::reg_idx_t mem_rd_i,
  input  cpu_pkg::word_t    mem_result_i,
  input  logic              mem_memrd_i,
  output cpu_pkg::reg_idx_t rs1_addr_o,
  output cpu_pkg::reg_idx_t rs2_addr_o,
  output cpu_pkg::alu_op_e  aluop_o,
  output cpu_pkg::word_t    op_a_o,
  output cpu_pkg::word_t    op_b_o,
  output cpu_pkg::word_t    store_data_o,
  output cpu_pkg::reg_idx_t rd_o,
  output logic              wreg_o,
  output logic              memrd_o,
  output logic              memwr_o,
  output logic              branch_taken_o,
  output cpu_pkg::addr_t    branch_target_o,
  output logic              stallreq_o,
  output logic              flush_o
);
  import cpu_pkg::*;

  opcode_e opcode;
  logic [2:0] funct3;
  word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  word_t rs1_val, rs2_val;
  logic uses_rs1, uses_rs2, wreg, taken;

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];
  assign rd_o = inst_i[11:7];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'h000};
  assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // Newest producer wins; x0 never has wreg set
  function automatic word_t fwd(reg_idx_t idx, word_t rf_val);
    if (ex_wreg_i && ex_rd_i == idx) return ex_result_i;
    if (mem_wreg_i && mem_rd_i == idx) return mem_result_i;
    return rf_val;
  endfunction

  // Load data only shows up once the load reaches writeback
  function automatic logic load_hit(reg_idx_t idx);
    return (ex_wreg_i && ex_memrd_i && ex_rd_i == idx) ||
           (mem_wreg_i && mem_memrd_i && mem_rd_i == idx);
  endfunction

  function automatic alu_op_e alu_sel(logic [2:0] f3, logic sub);
    case (f3)
      3'b000:  return sub ? ALU_SUB : ALU_ADD;
      3'b010:  return ALU_SLT;
      3'b100:  return ALU_XOR;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign rs1_val = fwd(rs1_addr_o, rs1_data_i);
  assign rs2_val = fwd(rs2_addr_o, rs2_data_i);
  assign store_data_o = rs2_val;

  always_comb begin
    aluop_o = ALU_ADD;
    op_a_o = rs1_val;
    op_b_o = rs2_val;
    wreg = 1'b0;
    memrd_o = 1'b0;
    memwr_o = 1'b0;
    taken = 1'b0;
    branch_target_o = pc_i + imm_b;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      OP: begin
        aluop_o = alu_sel(funct3, inst_i[30]);
        wreg = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OP_IMM: begin
        aluop_o = alu_sel(funct3, 1'b0);
        op_b_o = imm_i;
        wreg = 1'b1;
        uses_rs1 = 1'b1;
      end
      LUI: begin
        aluop_o = ALU_PASSB;
        op_b_o = imm_u;
        wreg = 1'b1;
      end
      LOAD: begin
        op_b_o = imm_i;
        wreg = 1'b1;
        memrd_o = 1'b1;
        uses_rs1 = 1'b1;
      end
      STORE: begin
        op_b_o = imm_s;
        memwr_o = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      BRANCH: begin
        // funct3[0] selects BNE
        taken = funct3[0] ^ (rs1_val == rs2_val);
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      JAL: begin
        aluop_o = ALU_PASSB;
        op_b_o = pc_i + 32'd4;
        wreg = 1'b1;
        taken = 1'b1;
        branch_target_o = pc_i + imm_j;
      end
      default: ;
    endcase
  end

  assign wreg_o = wreg && (rd_o != '0);
  assign stallreq_o = (uses_rs1 && load_hit(rs1_addr_o)) ||
                      (uses_rs2 && load_hit(rs2_addr_o));
  // Operands are stale during a load-use stall
  assign branch_taken_o = taken && !stallreq_o;
  assign flush_o = branch_taken_o;

endmodule

`default_nettype wire

/* design/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic [cpu_pkg::STAGE_NUM-1:0] stall_i,
  input  cpu_pkg::alu_op_e              aluop_i,
  input  cpu_pkg::word_t                op_a_i,
  input  cpu_pkg::word_t                op_b_i,
  input  cpu_pkg::word_t                store_data_i,
  input  cpu_pkg::reg_idx_t             rd_i,
  input  logic                          wreg_i,
  input  logic                          memrd_i,
  input  logic                          memwr_i,
  output cpu_pkg::word_t                ex_result_o,
  output cpu_pkg::word_t                ex_store_data_o,
  output cpu_pkg::reg_idx_t             ex_rd_o,
  output logic                          ex_wreg_o,
  output logic                          ex_memrd_o,
  output logic                          ex_memwr_o
);
  import cpu_pkg::*;

  alu_op_e aluop;
  word_t   op_a, op_b;

  // ID/EX register
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ex_wreg_o  <= 1'b0;
      ex_memrd_o <= 1'b0;
      ex_memwr_o <= 1'b0;
    end else if (stall_i[1] && !stall_i[2]) begin
      // Bubble behind a held decode
      ex_wreg_o  <= 1'b0;
      ex_memrd_o <= 1'b0;
      ex_memwr_o <= 1'b0;
    end else if (!stall_i[2]) begin
      ex_wreg_o  <= wreg_i;
      ex_memrd_o <= memrd_i;
      ex_memwr_o <= memwr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i[2]) begin
      aluop           <= aluop_i;
      op_a            <= op_a_i;
      op_b            <= op_b_i;
      ex_store_data_o <= store_data_i;
      ex_rd_o         <= rd_i;
    end
  end

  always_comb begin
    case (aluop)
      ALU_SUB:   ex_result_o = op_a - op_b;
      ALU_AND:   ex_result_o = op_a & op_b;
      ALU_OR:    ex_result_o = op_a | op_b;
      ALU_XOR:   ex_result_o = op_a ^ op_b;
      ALU_SLT:   ex_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_PASSB: ex_result_o = op_b;
      default:   ex_result_o = op_a + op_b;
    endcase
  end

endmodule

`default_nettype wire

/* design/memory.sv */
`timescale 1ns/1ps
`default_nettype none

module memory (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic [cpu_pkg::STAGE_NUM-1:0] stall_i,
  input  cpu_pkg::word_t                ex_result_i,
  input  cpu_pkg::word_t                ex_store_data_i,
  input  cpu_pkg::reg_idx_t             ex_rd_i,
  input  logic                          ex_wreg_i,
  input  logic                          ex_memrd_i,
  input  logic                          ex_memwr_i,
  output cpu_pkg::word_t                mem_result_o,
  output cpu_pkg::reg_idx_t             mem_rd_o,
  output logic                          mem_wreg_o,
  output logic                          mem_memrd_o,
  output logic                          data_read_o,
  output logic                          data_write_o,
  output cpu_pkg::addr_t                data_addr_o,
  output cpu_pkg::word_t                data_out_o
);
  import cpu_pkg::*;

  logic memwr;

  // EX/MEM register
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mem_wreg_o  <= 1'b0;
      mem_memrd_o <= 1'b0;
      memwr       <= 1'b0;
    end else if (stall_i[2] && !stall_i[3]) begin
      mem_wreg_o  <= 1'b0;
      mem_memrd_o <= 1'b0;
      memwr       <= 1'b0;
    end else if (!stall_i[3]) begin
      mem_wreg_o  <= ex_wreg_i;
      mem_memrd_o <= ex_memrd_i;
      memwr       <= ex_memwr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i[3]) begin
      mem_result_o <= ex_result_i;
      data_out_o   <= ex_store_data_i;
      mem_rd_o     <= ex_rd_i;
    end
  end

  // One strobe per access, issued in the cycle the stage advances
  assign data_read_o  = mem_memrd_o && !stall_i[3];
  assign data_write_o = memwr && !stall_i[3];
  assign data_addr_o  = mem_result_o;

endmodule

`default_nettype wire

/* design/writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic [cpu_pkg::STAGE_NUM-1:0] stall_i,
  input  cpu_pkg::word_t                mem_result_i,
  input  cpu_pkg::reg_idx_t             mem_rd_i,
  input  logic                          mem_wreg_i,
  input  logic                          mem_memrd_i,
  input  cpu_pkg::word_t                data_in_i,
  output logic                          wb_we_o,
  output cpu_pkg::reg_idx_t             wb_rd_o,
  output cpu_pkg::word_t                wb_data_o
);
  import cpu_pkg::*;

  word_t result;
  logic  is_load;

  // MEM/WB register
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wb_we_o <= 1'b0;
      is_load <= 1'b0;
    end else if (stall_i[3] && !stall_i[4]) begin
      wb_we_o <= 1'b0;
      is_load <= 1'b0;
    end else if (!stall_i[4]) begin
      wb_we_o <= mem_wreg_i;
      is_load <= mem_memrd_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i[4]) begin
      result  <= mem_result_i;
      wb_rd_o <= mem_rd_i;
    end
  end

  // Read data arrives while the load sits here
  assign wb_data_o = is_load ? data_in_i : result;

endmodule

`default_nettype wire

/* design/stall_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module stall_ctrl (
  input  logic                          stallreq_imem_i,
  input  logic                          stallreq_id_i,
  input  logic                          stallreq_dmem_i,
  output logic [cpu_pkg::STAGE_NUM-1:0] stall_o
);
  import cpu_pkg::*;

  always_comb begin
    stall_o = '0;
    if (stallreq_imem_i || stallreq_dmem_i) begin
      // Memory wait freezes everything
      stall_o = '1;
    end else if (stallreq_id_i) begin
      // Hold PC and IF/ID, execute takes a bubble
      stall_o[1:0] = 2'b11;
    end
  end

endmodule

`default_nettype wire

/* design/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter cpu_pkg::addr_t RESET_PC = 32'h0
) (
  input  logic           clk,
  input  logic           rstn,
  input  cpu_pkg::inst_t inst_in_i,
  output logic           inst_read_o,
  output cpu_pkg::addr_t inst_addr_o,
  input  cpu_pkg::word_t data_in_i,
  output logic           data_read_o,
  output logic           data_write_o,
  output cpu_pkg::addr_t data_addr_o,
  output cpu_pkg::word_t data_out_o,
  input  logic           stallreq_from_imem,
  input  logic           stallreq_from_dmem
);
  import cpu_pkg::*;

  logic [STAGE_NUM-1:0] stall;
  logic stallreq_id, flush, branch_taken;
  addr_t branch_target, id_pc;
  inst_t id_inst;

  reg_idx_t rs1_addr, rs2_addr, id_rd, ex_rd, mem_rd, wb_rd;
  word_t rs1_data, rs2_data, op_a, op_b, id_store_data;
  alu_op_e id_aluop;
  logic id_wreg, id_memrd, id_memwr;

  word_t ex_result, ex_store_data, mem_result, wb_data;
  logic ex_wreg, ex_memrd, ex_memwr;
  logic mem_wreg, mem_memrd, wb_we;

  regfile u_regfile (
    .clk(clk), .rstn(rstn),
    .we_i(wb_we), .waddr_i(wb_rd), .wdata_i(wb_data),
    .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
    .rdata1_o(rs1_data), .rdata2_o(rs2_data)
  );

  stall_ctrl u_stall_ctrl (
    .stallreq_imem_i(stallreq_from_imem),
    .stallreq_id_i  (stallreq_id),
    .stallreq_dmem_i(stallreq_from_dmem),
    .stall_o        (stall)
  );

  fetch #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .rstn(rstn), .stall_i(stall), .flush_i(flush),
    .branch_taken_i(branch_taken), .branch_target_i(branch_target),
    .inst_i(inst_in_i), .inst_read_o(inst_read_o), .inst_addr_o(inst_addr_o),
    .id_pc_o(id_pc), .id_inst_o(id_inst)
  );

  decode u_decode (
    .pc_i(id_pc), .inst_i(id_inst),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .ex_wreg_i(ex_wreg), .ex_rd_i(ex_rd), .ex_result_i(ex_result),
    .ex_memrd_i(ex_memrd), .mem_wreg_i(mem_wreg), .mem_rd_i(mem_rd),
    .mem_result_i(mem_result), .mem_memrd_i(mem_memrd),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .aluop_o(id_aluop),
    .op_a_o(op_a), .op_b_o(op_b), .store_data_o(id_store_data),
    .rd_o(id_rd), .wreg_o(id_wreg), .memrd_o(id_memrd), .memwr_o(id_memwr),
    .branch_taken_o(branch_taken), .branch_target_o(branch_target),
    .stallreq_o(stallreq_id), .flush_o(flush)
  );

  execute u_execute (
    .clk(clk), .rstn(rstn), .stall_i(stall),
    .aluop_i(id_aluop), .op_a_i(op_a), .op_b_i(op_b),
    .store_data_i(id_store_data), .rd_i(id_rd), .wreg_i(id_wreg),
    .memrd_i(id_memrd), .memwr_i(id_memwr),
    .ex_result_o(ex_result), .ex_store_data_o(ex_store_data), .ex_rd_o(ex_rd),
    .ex_wreg_o(ex_wreg), .ex_memrd_o(ex_memrd), .ex_memwr_o(ex_memwr)
  );

  memory u_memory (
    .clk(clk), .rstn(rstn), .stall_i(stall),
    .ex_result_i(ex_result), .ex_store_data_i(ex_store_data), .ex_rd_i(ex_rd),
    .ex_wreg_i(ex_wreg), .ex_memrd_i(ex_memrd), .ex_memwr_i(ex_memwr),
    .mem_result_o(mem_result), .mem_rd_o(mem_rd), .mem_wreg_o(mem_wreg),
    .mem_memrd_o(mem_memrd), .data_read_o(data_read_o), .data_write_o(data_write_o),
    .data_addr_o(data_addr_o), .data_out_o(data_out_o)
  );

  writeback u_writeback (
    .clk(clk), .rstn(rstn), .stall_i(stall),
    .mem_result_i(mem_result), .mem_rd_i(mem_rd), .mem_wreg_i(mem_wreg),
    .mem_memrd_i(mem_memrd), .data_in_i(data_in_i),
    .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
  );

endmodule

`default_nettype wire

/* dv/cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
  input wire        clk,
  input wire        rstn,
  input wire        data_read_i,
  input wire        data_write_i,
  input wire [31:0] inst_addr_i,
  input wire        stallreq_imem_i
);

  a_rw_exclusive: assert property (
    @(posedge clk) disable iff (!rstn) !(data_read_i && data_write_i)
  ) else $error("data read and write strobes high in the same cycle");

  a_inst_aligned: assert property (
    @(posedge clk) disable iff (!rstn) inst_addr_i[1:0] == 2'b00
  ) else $error("instruction address not word aligned");

  // Pipeline is all bubbles right after reset
  a_quiet_after_reset: assert property (
    @(posedge clk) $rose(rstn) |-> !data_read_i && !data_write_i
  ) else $error("data strobe high in the first cycle after reset");

  a_pc_held: assert property (
    @(posedge clk) disable iff (!rstn) stallreq_imem_i |=> $stable(inst_addr_i)
  ) else $error("instruction address moved during an imem stall");

endmodule

bind cpu_top cpu_checker u_checker (
  .clk            (clk),
  .rstn           (rstn),
  .data_read_i    (data_read_o),
  .data_write_i   (data_write_o),
  .inst_addr_i    (inst_addr_o),
  .stallreq_imem_i(stallreq_from_imem)
);

`default_nettype wire

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  localparam int STIM_WORDS = 512;
  localparam int MEM_WORDS  = 256;
  localparam int TAIL_CYCLES = 50;

  logic  clk;
  logic  rstn;
  inst_t inst_in;
  logic  inst_read;
  addr_t inst_addr;
  word_t data_in = '0;
  logic  data_read;
  logic  data_write;
  addr_t data_addr;
  word_t data_out;
  logic  imem_stall = 1'b0;
  logic  dmem_stall = 1'b0;

  logic [31:0] stim [STIM_WORDS];
  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  addr_t exp_addr [$];
  word_t exp_data [$];

  int n_prog;
  int n_stores;
  int store_idx = 0;
  int cycles = 0;
  int timeout_cycles = 0;
  logic [31:0] lfsr = 32'hd443d612;
  logic rstn_q = 1'b0;
  logic reset_seen = 1'b0;

  cpu_top #(.RESET_PC(32'h0)) uut (
    .clk(clk), .rstn(rstn),
    .inst_in_i(inst_in), .inst_read_o(inst_read), .inst_addr_o(inst_addr),
    .data_in_i(data_in), .data_read_o(data_read), .data_write_o(data_write),
    .data_addr_o(data_addr), .data_out_o(data_out),
    .stallreq_from_imem(imem_stall), .stallreq_from_dmem(dmem_stall)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped on first error");
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task next_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b = lfsr[0];
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Instruction memory answers in the same cycle
  assign inst_in = imem[inst_addr[9:2]];

  // Read data lands one cycle after the strobe
  always @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else begin
      if (data_write) begin
        dmem[data_addr[9:2]] <= data_out;
      end
      if (data_read) begin
        data_in <= dmem[data_addr[9:2]];
      end
    end
  end

  // Each request fires when two LFSR bits are both set
  always @(posedge clk) begin
    logic b0, b1, b2, b3;
    if (!rstn) begin
      imem_stall <= 1'b0;
      dmem_stall <= 1'b0;
    end else begin
      next_bit(b0);
      next_bit(b1);
      next_bit(b2);
      next_bit(b3);
      imem_stall <= b0 && b1;
      dmem_stall <= b2 && b3;
    end
  end

  // Fetch strobe is low in reset and rises one cycle after release
  always @(posedge clk) begin
    rstn_q <= rstn;
    if (!rstn) begin
      reset_seen <= 1'b1;
    end
    if (reset_seen) begin
      assert (inst_read == rstn_q) else begin
        fail_run($sformatf("mismatch at %0t: inst_read_o expected %b, got %b",
                           $time, rstn_q, inst_read));
      end
    end
  end

  // Store stream monitor
  always @(posedge clk) begin
    addr_t e_addr;
    word_t e_data;
    if (rstn && data_write) begin
      assert (store_idx < n_stores)
        else fail_run("a store appeared after the last expected store");
      if (store_idx < n_stores) begin
        e_addr = exp_addr[store_idx];
        e_data = exp_data[store_idx];
        store_idx++;
        assert (data_addr == e_addr && data_out == e_data) else begin
          if (data_addr != e_addr) begin
            fail_run($sformatf("mismatch at %0t: data_addr_o expected %h, got %h",
                               $time, e_addr, data_addr));
          end else begin
            fail_run($sformatf("mismatch at %0t: data_out_o expected %h, got %h",
                               $time, e_data, data_out));
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (timeout_cycles > 0 && cycles >= timeout_cycles) begin
      fail_run($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                         cycles, store_idx, n_stores));
    end
  end

  initial begin
    rstn = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = NOP;
    end
    $readmemh("dv/cpu_stim.txt", stim);
    n_prog   = stim[0];
    n_stores = stim[1];
    if (n_prog < 1 || n_prog > MEM_WORDS || n_stores < 1 ||
        2 + n_prog + 2 * n_stores > STIM_WORDS) begin
      fail_run("stimulus file has bad program or store counts");
    end else begin
      for (int i = 0; i < n_prog; i++) begin
        imem[i] = stim[2 + i];
      end
      for (int i = 0; i < n_stores; i++) begin
        exp_addr.push_back(stim[2 + n_prog + 2 * i]);
        exp_data.push_back(stim[3 + n_prog + 2 * i]);
      end
      // Random stalls stretch the run
      timeout_cycles = 20 * n_prog + 200;

      repeat (10) @(posedge clk);
      rstn <= 1'b1;

      while (store_idx < n_stores) begin
        @(posedge clk);
      end
      // Program spins in its JAL loop
      repeat (TAIL_CYCLES) @(posedge clk);

      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/cpu_stim.txt */
// Word 0 program length, word 1 store count (hex)
// Then program words, then expected stores as address and data pairs
00000029
0000000E
00500093 // addi x1, x0, 5
00708113 // addi x2, x1, 7
002081B3 // add  x3, x1, x2
40118233 // sub  x4, x3, x1
0011F2B3 // and  x5, x3, x1
00126333 // or   x6, x4, x1
003343B3 // xor  x7, x6, x3
10302023 // sw   x3, 0x100(x0)
10402223 // sw   x4, 0x104(x0)
10502423 // sw   x5, 0x108(x0)
10602623 // sw   x6, 0x10c(x0)
10702823 // sw   x7, 0x110(x0)
FFD00413 // addi x8, x0, -3
001424B3 // slt  x9, x8, x1
0080A533 // slt  x10, x1, x8
123455B7 // lui  x11, 0x12345
67858593 // addi x11, x11, 0x678
10902A23 // sw   x9, 0x114(x0)
10A02C23 // sw   x10, 0x118(x0)
10B02E23 // sw   x11, 0x11c(x0)
12802023 // sw   x8, 0x120(x0)
11C02603 // lw   x12, 0x11c(x0)
001606B3 // add  x13, x12, x1
12D02223 // sw   x13, 0x124(x0)
10402703 // lw   x14, 0x104(x0)
12E02423 // sw   x14, 0x128(x0)
00208463 // beq  x1, x2, +8 not taken
12102623 // sw   x1, 0x12c(x0)
00209463 // bne  x1, x2, +8 taken
1E202823 // sw   x2, 0x1f0(x0) wrong path
00220463 // beq  x4, x2, +8 taken
1E202A23 // sw   x2, 0x1f4(x0) wrong path
00221463 // bne  x4, x2, +8 not taken
12402823 // sw   x4, 0x130(x0)
00C00793 // addi x15, x0, 12
00478463 // beq  x15, x4, +8 taken
1EF02C23 // sw   x15, 0x1f8(x0) wrong path
0080086F // jal  x16, +8
1F002E23 // sw   x16, 0x1fc(x0) wrong path
13002A23 // sw   x16, 0x134(x0)
0000006F // jal  x0, 0
00000100 00000011
00000104 0000000C
00000108 00000001
0000010C 0000000D
00000110 0000001C
00000114 00000001
00000118 00000000
0000011C 12345678
00000120 FFFFFFFD
00000124 1234567D
00000128 0000000C
0000012C 00000005
00000130 0000000C
00000134 00000098

/* vlog.f */
design/cpu_pkg.sv
design/regfile.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/writeback.sv
design/stall_ctrl.sv
design/cpu_top.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= cpu_tb
FILELIST  ?= vlog.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
